// ==== compile.f ====
+incdir+include
source/mont_types_pkg.sv
source/mont_fsm_pkg.sv
source/mp_adder_if.sv
source/mp_adder.sv
source/mont_datapath.sv
source/mont_controller.sv
source/montgomery.sv
verification/mont_asserts.sv
verification/tb_montgomery.sv

// ==== Bender.yml ====
package:
  name: montgomery

sources:
  - include_dirs:
      - include
    files:
      - source/mont_types_pkg.sv
      - source/mont_fsm_pkg.sv
      - source/mp_adder_if.sv
      - source/mp_adder.sv
      - source/mont_datapath.sv
      - source/mont_controller.sv
      - source/montgomery.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/mont_asserts.sv
      - verification/tb_montgomery.sv

// ==== include/mont_ref_model.svh ====
`ifndef MONT_REF_MODEL_SVH
`define MONT_REF_MODEL_SVH

`include "mont_config.svh"

// Digit loop only, without the final reduction
function automatic logic [`MONT_EXT_WIDTH-1:0] mont_ref_loop(
    input logic [`MONT_WIDTH-1:0] a,
    input logic [`MONT_WIDTH-1:0] b,
    input logic [`MONT_WIDTH-1:0] m
);
    logic [`MONT_EXT_WIDTH-1:0] c;
    logic [`MONT_EXT_WIDTH-1:0] bx;
    logic [`MONT_EXT_WIDTH-1:0] mx;
    logic [`MONT_EXT_WIDTH-1:0] t;
    logic [`MONT_EXT_WIDTH-1:0] s;
    c  = '0;
    bx = b;
    mx = m;
    s  = '0;
    for (int i = 0; i < `MONT_DIGITS; i++) begin
        c = c + bx * a[2*i +: 2];
        // Multiple of m that clears the two low bits
        t = c;
        for (int k = 0; k < 4; k++) begin
            if (t[1:0] == 2'b00) begin
                s = t;
            end
            t = t + mx;
        end
        c = s >> 2;
    end
    return c;
endfunction

// Full product a*b*4^-D mod m
function automatic logic [`MONT_WIDTH-1:0] mont_ref(
    input logic [`MONT_WIDTH-1:0] a,
    input logic [`MONT_WIDTH-1:0] b,
    input logic [`MONT_WIDTH-1:0] m
);
    logic [`MONT_EXT_WIDTH-1:0] c;
    c = mont_ref_loop(a, b, m);
    if (c >= m) begin
        c = c - m;
    end
    return c[`MONT_WIDTH-1:0];
endfunction

`endif

// ==== verification/tb_montgomery.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mont_config.svh"
`include "mont_ref_model.svh"

module tb_montgomery;

    typedef mont_types_pkg::operand_t word_t;

    localparam int W          = `MONT_WIDTH;
    localparam int CLK_PERIOD = 40;
    localparam int NUM_OPS    = 16;
    // Upper bound for one operation, in clock cycles
    localparam int OP_CYCLES  = (2 * `MONT_DIGITS + 3) * (`MP_ADDER_STAGES + 3);
    localparam int WATCHDOG_NS = (NUM_OPS * OP_CYCLES + 2000) * CLK_PERIOD;

    logic        clk = 1'b0;
    logic        resetn;
    logic        start;
    word_t       in_a;
    word_t       in_b;
    word_t       in_m;
    word_t       result;
    logic        done;
    logic [31:0] lcg_state = 32'd88;
    int unsigned done_count = 0;

    montgomery u_dut (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .result (result),
        .done   (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        if (done) begin
            done_count++;
        end
    end

    // Bound checks in the controller
    always @(negedge clk) begin
        assert (u_dut.u_controller.u_asserts.fail_count == 0) else begin
            $display("a bound assertion in the controller failed");
            abort_run();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        abort_run();
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t random_wide();
        word_t v;
        for (int i = 0; i < W / 32; i++) begin
            v[32*i +: 32] = lcg_next();
        end
        return v;
    endfunction

    // Odd and with the top bit set, so the loop result can reach m
    function automatic word_t random_modulus();
        word_t v;
        v        = random_wide();
        v[0]     = 1'b1;
        v[W-1]   = 1'b1;
        return v;
    endfunction

    function automatic word_t random_below(input word_t m);
        return random_wide() % m;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("error: %s expected 0x%h actual 0x%h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic apply_start(input word_t a, input word_t b, input word_t m);
        @(posedge clk);
        start <= 1'b1;
        in_a  <= a;
        in_b  <= b;
        in_m  <= m;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done) begin
            assert (cycles < OP_CYCLES) else begin
                $display("timeout while waiting for done");
                abort_run();
            end
            cycles++;
            @(negedge clk);
        end
        // One cycle pulse only
        @(negedge clk);
        check_value("done", '0, word_t'(done));
    endtask

    task automatic run_product(input word_t a, input word_t b, input word_t m);
        apply_start(a, b, m);
        wait_done();
        check_value("result", mont_ref(a, b, m), result);
        assert (result < m) else begin
            $display("result is not below the modulus");
            abort_run();
        end
    endtask

    task automatic test_reset_idle();
        @(negedge clk);
        check_value("done", '0, word_t'(done));
        check_value("result", '0, result);
        repeat (50) begin
            @(negedge clk);
            check_value("done", '0, word_t'(done));
        end
    endtask

    task automatic test_directed();
        word_t m;
        m = random_modulus();
        run_product('0, random_below(m), m);
        check_value("result", '0, result);
        run_product(word_t'(1), word_t'(1), m);
        // All ones modulus hits every multiple and quotient digit
        m = '1;
        run_product(m - 1'b1, m - 1'b1, m);
    endtask

    task automatic test_random();
        word_t m;
        for (int i = 0; i < 8; i++) begin
            m = random_modulus();
            run_product(random_below(m), random_below(m), m);
        end
    endtask

    // Loop result at or above m when want_high is set, below m otherwise
    task automatic test_reduction(input bit want_high);
        word_t m;
        word_t a;
        word_t b;
        bit    found;
        m     = random_modulus();
        found = 1'b0;
        for (int i = 0; i < 64 && !found; i++) begin
            a     = random_below(m);
            b     = random_below(m);
            found = ((mont_ref_loop(a, b, m) >= m) == want_high);
        end
        assert (found) else begin
            $display("no operand pair found for the final reduction case");
            abort_run();
        end
        run_product(a, b, m);
    endtask

    task automatic test_busy_and_hold();
        word_t       m;
        word_t       a;
        word_t       b;
        word_t       held;
        int unsigned count_before;
        m            = random_modulus();
        a            = random_below(m);
        b            = random_below(m);
        count_before = done_count;
        apply_start(a, b, m);
        repeat (20) @(posedge clk);
        // Ignored while busy
        apply_start(random_below(m), random_below(m), random_modulus());
        wait_done();
        check_value("result", mont_ref(a, b, m), result);
        held = result;
        repeat (20) begin
            @(negedge clk);
            check_value("result", held, result);
            check_value("done", '0, word_t'(done));
        end
        run_product(b, a, m);
        run_product(a, a, m);
        check_value("done_count", word_t'(count_before + 3), word_t'(done_count));
    endtask

    initial begin
        resetn = 1'b0;
        start  = 1'b0;
        in_a   = '0;
        in_b   = '0;
        in_m   = '0;
        repeat (8) @(posedge clk);
        resetn <= 1'b1;
        test_reset_idle();
        test_directed();
        test_random();
        test_reduction(1'b1);
        test_reduction(1'b0);
        test_busy_and_hold();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/mont_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mont_config.svh"

module mont_asserts (
    input wire logic                      clk,
    input wire logic                      resetn,
    input wire mont_fsm_pkg::mont_state_e state,
    input wire logic                      done,
    input wire logic                      commit,
    input wire logic                      adder_start,
    input wire logic                      adder_done
);

    localparam int STAGES = `MP_ADDER_STAGES;

    // Failures so far, polled by the testbench
    int unsigned fail_count = 0;

    done_single_pulse: assert property (@(posedge clk) disable iff (!resetn) done |=> !done)
        else begin
            fail_count++;
            $error("done stayed high for two cycles");
        end

    // Adder latency is fixed by the chunk count
    adder_latency: assert property (@(posedge clk) disable iff (!resetn)
        adder_start |-> ##STAGES adder_done)
        else begin
            fail_count++;
            $error("adder done did not follow start after %0d cycles", STAGES);
        end

    // Commit lands on the cycle the adder finishes its operation
    commit_on_done: assert property (@(posedge clk) disable iff (!resetn)
        commit |-> $past(adder_start, STAGES))
        else begin
            fail_count++;
            $error("commit without a finished adder operation");
        end

    idle_after_reset: assert property (@(posedge clk)
        $rose(resetn) |-> state == mont_fsm_pkg::ST_IDLE)
        else begin
            fail_count++;
            $error("controller not idle after reset");
        end

endmodule

bind mont_controller mont_asserts u_asserts (
    .clk         (clk),
    .resetn      (resetn),
    .state       (state),
    .done        (done),
    .commit      (commit),
    .adder_start (adder.start),
    .adder_done  (adder.done)
);

`default_nettype wire

// ==== source/montgomery.sv ====
`timescale 1ns/100ps
`default_nettype none

module montgomery (
    input  wire logic                      clk,
    input  wire logic                      resetn,
    input  wire logic                      start,
    input  wire mont_types_pkg::operand_t  in_a,
    input  wire mont_types_pkg::operand_t  in_b,
    input  wire mont_types_pkg::operand_t  in_m,
    output mont_types_pkg::operand_t       result,
    output logic                           done
);

    logic                    load;
    mont_types_pkg::addend_e addend_sel;
    logic                    commit;

    mp_adder_if adder_bus ();

    mont_controller u_controller (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .load       (load),
        .addend_sel (addend_sel),
        .commit     (commit),
        .done       (done),
        .adder      (adder_bus.control)
    );

    mont_datapath u_datapath (
        .clk        (clk),
        .resetn     (resetn),
        .in_a       (in_a),
        .in_b       (in_b),
        .in_m       (in_m),
        .load       (load),
        .addend_sel (addend_sel),
        .commit     (commit),
        .result     (result),
        .adder      (adder_bus.operands)
    );

    mp_adder u_adder (
        .clk    (clk),
        .resetn (resetn),
        .bus    (adder_bus.unit)
    );

endmodule

`default_nettype wire

// ==== source/mont_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mont_config.svh"

module mont_controller (
    input  wire logic                 clk,
    input  wire logic                 resetn,
    input  wire logic                 start,
    output logic                      load,
    output mont_types_pkg::addend_e   addend_sel,
    output logic                      commit,
    output logic                      done,
    mp_adder_if.control               adder
);

    localparam int DIGIT_W = (`MONT_DIGITS > 1) ? $clog2(`MONT_DIGITS) : 1;

    mont_fsm_pkg::mont_state_e state;
    mont_fsm_pkg::mont_state_e state_next;
    logic                      issued;
    logic                      arith;
    logic [DIGIT_W-1:0]        digit;
    logic                      last_digit;

    // Every state other than idle and done owns one adder operation
    assign arith = (state != mont_fsm_pkg::ST_IDLE) && (state != mont_fsm_pkg::ST_DONE);

    assign load        = (state == mont_fsm_pkg::ST_IDLE) && start;
    assign adder.start = arith && !issued;
    assign commit      = arith && adder.done;
    assign done        = (state == mont_fsm_pkg::ST_DONE);
    assign last_digit  = (digit == DIGIT_W'(`MONT_DIGITS - 1));

    always_comb begin
        case (state)
            mont_fsm_pkg::ST_TRIPLE_M: addend_sel = mont_types_pkg::ADD_TRIPLE_M;
            mont_fsm_pkg::ST_DIGIT_B:  addend_sel = mont_types_pkg::ADD_DIGIT_B;
            mont_fsm_pkg::ST_QUOT_M:   addend_sel = mont_types_pkg::ADD_QUOT_M;
            mont_fsm_pkg::ST_REDUCE:   addend_sel = mont_types_pkg::SUB_MOD;
            default:                   addend_sel = mont_types_pkg::ADD_TRIPLE_B;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            mont_fsm_pkg::ST_IDLE: begin
                if (start) begin
                    state_next = mont_fsm_pkg::ST_TRIPLE_B;
                end
            end
            mont_fsm_pkg::ST_TRIPLE_B: begin
                if (adder.done) begin
                    state_next = mont_fsm_pkg::ST_TRIPLE_M;
                end
            end
            mont_fsm_pkg::ST_TRIPLE_M: begin
                if (adder.done) begin
                    state_next = mont_fsm_pkg::ST_DIGIT_B;
                end
            end
            mont_fsm_pkg::ST_DIGIT_B: begin
                if (adder.done) begin
                    state_next = mont_fsm_pkg::ST_QUOT_M;
                end
            end
            mont_fsm_pkg::ST_QUOT_M: begin
                // Loop back for the next digit until all are consumed
                if (adder.done) begin
                    state_next = last_digit ? mont_fsm_pkg::ST_REDUCE
                                            : mont_fsm_pkg::ST_DIGIT_B;
                end
            end
            mont_fsm_pkg::ST_REDUCE: begin
                if (adder.done) begin
                    state_next = mont_fsm_pkg::ST_DONE;
                end
            end
            default: begin
                state_next = mont_fsm_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state  <= mont_fsm_pkg::ST_IDLE;
            issued <= 1'b0;
            digit  <= '0;
        end else begin
            state <= state_next;
            // Single start pulse per arithmetic state
            if (adder.done) begin
                issued <= 1'b0;
            end else if (adder.start) begin
                issued <= 1'b1;
            end
            if (load) begin
                digit <= '0;
            end else if (commit && state == mont_fsm_pkg::ST_QUOT_M) begin
                digit <= digit + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/mont_datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mont_config.svh"

module mont_datapath (
    input  wire logic                      clk,
    input  wire logic                      resetn,
    input  wire mont_types_pkg::operand_t  in_a,
    input  wire mont_types_pkg::operand_t  in_b,
    input  wire mont_types_pkg::operand_t  in_m,
    input  wire logic                      load,
    input  wire mont_types_pkg::addend_e   addend_sel,
    input  wire logic                      commit,
    output mont_types_pkg::operand_t       result,
    mp_adder_if.operands                   adder
);

    mont_types_pkg::operand_t a;
    mont_types_pkg::operand_t b;
    mont_types_pkg::operand_t m;
    mont_types_pkg::ext_t     b3;
    mont_types_pkg::ext_t     m3;
    mont_types_pkg::ext_t     c;
    mont_types_pkg::ext_t     b_ext;
    mont_types_pkg::ext_t     m_ext;
    mont_types_pkg::ext_t     b_mult;
    mont_types_pkg::ext_t     q_mult;
    logic [1:0]               q_sel;
    logic                     borrow;

    // Picks 0, x, 2x or 3x
    function automatic mont_types_pkg::ext_t multiple(
        input logic [1:0]           sel,
        input mont_types_pkg::ext_t x,
        input mont_types_pkg::ext_t x3
    );
        case (sel)
            2'd0:    return '0;
            2'd1:    return x;
            2'd2:    return x << 1;
            default: return x3;
        endcase
    endfunction

    assign b_ext = mont_types_pkg::ext_t'(b);
    assign m_ext = mont_types_pkg::ext_t'(m);

    // Quotient digit is -c * m^-1 mod 4, and m^-1 equals m mod 4
    assign q_sel  = m[1] ? c[1:0] : (2'b00 - c[1:0]);
    assign b_mult = multiple(a[1:0], b_ext, b3);
    assign q_mult = multiple(q_sel, m_ext, m3);

    assign borrow = adder.sum[`MONT_EXT_WIDTH-1];
    assign result = c[`MONT_WIDTH-1:0];

    always_comb begin
        adder.op_a     = c;
        adder.op_b     = '0;
        adder.subtract = 1'b0;
        case (addend_sel)
            mont_types_pkg::ADD_TRIPLE_B: begin
                adder.op_a = b_ext << 1;
                adder.op_b = b_ext;
            end
            mont_types_pkg::ADD_TRIPLE_M: begin
                adder.op_a = m_ext << 1;
                adder.op_b = m_ext;
            end
            mont_types_pkg::ADD_DIGIT_B: begin
                adder.op_b = b_mult;
            end
            mont_types_pkg::ADD_QUOT_M: begin
                adder.op_b = q_mult;
            end
            mont_types_pkg::SUB_MOD: begin
                adder.op_b     = m_ext;
                adder.subtract = 1'b1;
            end
            default: begin
                adder.op_b = '0;
            end
        endcase
    end

    // Operands and precomputed multiples
    always_ff @(posedge clk) begin
        if (load) begin
            a <= in_a;
            b <= in_b;
            m <= in_m;
        end else if (commit) begin
            case (addend_sel)
                mont_types_pkg::ADD_TRIPLE_B: b3 <= adder.sum;
                mont_types_pkg::ADD_TRIPLE_M: m3 <= adder.sum;
                // Next digit of a moves into the low bits
                mont_types_pkg::ADD_QUOT_M:   a <= a >> 2;
                default: ;
            endcase
        end
    end

    // Accumulator
    always_ff @(posedge clk) begin
        if (!resetn) begin
            c <= '0;
        end else if (load) begin
            c <= '0;
        end else if (commit) begin
            case (addend_sel)
                mont_types_pkg::ADD_DIGIT_B: c <= adder.sum;
                mont_types_pkg::ADD_QUOT_M:  c <= adder.sum >> 2;
                mont_types_pkg::SUB_MOD: begin
                    // Keep c - m only when it did not go negative
                    if (!borrow) begin
                        c <= adder.sum;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/mp_adder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mont_config.svh"

module mp_adder (
    input wire logic clk,
    input wire logic resetn,
    mp_adder_if.unit bus
);

    localparam int STAGES = `MP_ADDER_STAGES;
    localparam int CHUNK  = `MP_ADDER_CHUNK;
    localparam int CNT_W  = (STAGES > 1) ? $clog2(STAGES) : 1;

    logic             busy;
    logic [CNT_W-1:0] stage;
    logic             carry;
    logic             active;
    logic             last;
    logic [CNT_W-1:0] idx;
    logic             carry_in;
    logic [CHUNK-1:0] chunk_a;
    logic [CHUNK-1:0] chunk_b;
    logic [CHUNK:0]   chunk_sum;

    // Chunk 0 is already processed in the start cycle
    assign active   = bus.start || busy;
    assign idx      = bus.start ? '0 : stage;
    assign carry_in = bus.start ? bus.subtract : carry;
    assign last     = (idx == CNT_W'(STAGES - 1));

    // Subtraction as a + ~b + 1, the +1 enters as first carry
    assign chunk_a   = bus.op_a[idx*CHUNK +: CHUNK];
    assign chunk_b   = bus.op_b[idx*CHUNK +: CHUNK] ^ {CHUNK{bus.subtract}};
    assign chunk_sum = {1'b0, chunk_a} + {1'b0, chunk_b} + {{CHUNK{1'b0}}, carry_in};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy     <= 1'b0;
            stage    <= '0;
            carry    <= 1'b0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= active && last;
            if (active) begin
                carry <= chunk_sum[CHUNK];
                stage <= idx + 1'b1;
                busy  <= !last;
            end
        end
    end

    // Result word, holds until the next operation overwrites it
    always_ff @(posedge clk) begin
        if (active) begin
            bus.sum[idx*CHUNK +: CHUNK] <= chunk_sum[CHUNK-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== source/mp_adder_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface mp_adder_if;

    logic                 start;
    logic                 subtract;
    mont_types_pkg::ext_t op_a;
    mont_types_pkg::ext_t op_b;
    mont_types_pkg::ext_t sum;
    logic                 done;

    // Operand side, held steady from start until done
    modport operands (output op_a, output op_b, output subtract, input sum);

    modport control (output start, input done);

    modport unit (input start, input subtract, input op_a, input op_b,
                  output sum, output done);

endinterface

`default_nettype wire

// ==== source/mont_fsm_pkg.sv ====
`default_nettype none

package mont_fsm_pkg;

    // Controller sequence, one state per adder operation
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_TRIPLE_B,
        ST_TRIPLE_M,
        ST_DIGIT_B,
        ST_QUOT_M,
        ST_REDUCE,
        ST_DONE
    } mont_state_e;

endpackage

`default_nettype wire

// ==== source/mont_types_pkg.sv ====
`default_nettype none

`include "mont_config.svh"

package mont_types_pkg;

    typedef logic [`MONT_WIDTH-1:0] operand_t;

    // Accumulator, precomputed multiples and adder words
    typedef logic [`MONT_EXT_WIDTH-1:0] ext_t;

    // Operation currently on the adder
    typedef enum logic [2:0] {
        ADD_TRIPLE_B,
        ADD_TRIPLE_M,
        ADD_DIGIT_B,
        ADD_QUOT_M,
        SUB_MOD
    } addend_e;

endpackage

`default_nettype wire

// ==== include/mont_config.svh ====
`ifndef MONT_CONFIG_SVH
`define MONT_CONFIG_SVH

// Operand and modulus width in bits
`define MONT_WIDTH 1024

// Radix-4 digits per operand
`define MONT_DIGITS (`MONT_WIDTH / 2)

// Headroom for c + 3b + 3m and the borrow bit
`define MONT_EXT_WIDTH (`MONT_WIDTH + 4)

// Adder processes one chunk per cycle, MONT_EXT_WIDTH must divide evenly
`define MP_ADDER_STAGES 4
`define MP_ADDER_CHUNK (`MONT_EXT_WIDTH / `MP_ADDER_STAGES)

`endif
